/* src/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Data path widths
`define ALU_WORD_W    16          // Operand and result
`define ALU_BYTE_W    8           // Narrow operand
`define ALU_DIV_STEPS 16          // One quotient bit per step

// Condition-code bit positions
`define CC_C 0                    // Carry or borrow
`define CC_V 1                    // Signed overflow
`define CC_Z 2                    // Zero
`define CC_N 3                    // Negative
`define CC_I 4                    // IRQ mask
`define CC_H 5                    // Half carry
`define CC_F 6                    // FIRQ mask
`define CC_E 7                    // Entire state saved

`endif

/* src/alu_pkg.sv */
`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_WORD_W-1:0] word_t;
    typedef logic [`ALU_BYTE_W-1:0] byte_t;
    typedef logic [7:0]             cc_t;   // E F H I N Z V C

    typedef enum logic [7:0] {
        op_ld    = 8'h00,
        op_lea   = 8'h01,
        op_add8  = 8'h02,
        op_add16 = 8'h03,
        op_adc8  = 8'h04,
        op_sub8  = 8'h05,
        op_sub16 = 8'h06,
        op_sbc8  = 8'h07,
        op_and   = 8'h08,
        op_eor   = 8'h09,
        op_or    = 8'h0a,
        op_andcc = 8'h0b,
        op_orcc  = 8'h0c,
        op_clr   = 8'h0d,
        op_com   = 8'h0e,
        op_neg8  = 8'h0f,
        op_neg16 = 8'h10,
        op_inc8  = 8'h11,
        op_inc16 = 8'h12,
        op_dec8  = 8'h13,
        op_dec16 = 8'h14,
        op_lsr8  = 8'h15,
        op_lsr16 = 8'h16,
        op_asr8  = 8'h17,
        op_asl8  = 8'h18,
        op_ror8  = 8'h19,
        op_rol8  = 8'h1a,
        op_daa   = 8'h1b,
        op_sex   = 8'h1c,
        op_mul   = 8'h1d,
        op_lmul  = 8'h1e,
        op_abs8  = 8'h1f,
        op_abs16 = 8'h20,
        op_div   = 8'h21              // Only multi-cycle op
    } opcode_e;

    typedef struct packed {
        opcode_e op;
        word_t   opnd0;               // Register operand
        word_t   opnd1;               // Memory or immediate operand
    } alu_req_t;

    typedef struct packed {
        logic wide;                   // Flags taken from 16 bits
        logic up_n;
        logic up_z;
        logic is_div;
    } alu_ctl_t;

    typedef struct packed {
        word_t rslt;
        word_t rslt_hi;               // LMUL high half, DIV remainder
        cc_t   cc;
    } alu_out_t;

endpackage

/* src/op_decode.sv */
`timescale 1ns/1ps

module op_decode import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  logic     hold,
    input  alu_req_t req,
    output logic     stage_valid,
    output alu_req_t stage_req,
    output alu_ctl_t stage_ctl
);

    alu_ctl_t ctl_next;

    // Width class and flag rules per opcode
    always_comb begin
        ctl_next        = '0;
        ctl_next.up_n   = 1'b1;
        ctl_next.up_z   = 1'b1;
        case (req.op)
            op_ld, op_add16, op_sub16, op_and, op_eor, op_or,
            op_clr, op_com, op_neg16, op_inc16, op_dec16,
            op_lsr16, op_sex: begin
                ctl_next.wide = 1'b1;
            end
            op_lea, op_mul, op_lmul: begin
                ctl_next.wide = 1'b1;
                ctl_next.up_n = 1'b0;     // Z only, or C and Z
            end
            op_div: begin
                ctl_next.wide   = 1'b1;
                ctl_next.up_n   = 1'b0;
                ctl_next.is_div = 1'b1;
            end
            op_abs16: begin
                ctl_next.wide = 1'b1;
                ctl_next.up_z = 1'b0;
            end
            op_abs8: ctl_next.up_z = 1'b0;
            op_andcc, op_orcc: begin
                ctl_next.up_n = 1'b0;     // Flags come from the cc logic
                ctl_next.up_z = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= 1'b0;
            stage_ctl   <= '0;
        end else if (!hold) begin
            stage_valid <= issue;
            stage_ctl   <= ctl_next;
        end
    end

    // Operands load on an accepted issue
    always_ff @(posedge clk) begin
        if (!hold && issue) begin
            stage_req <= req;
        end
    end

endmodule

/* src/alu_core.sv */
`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_core import alu_pkg::*; (
    input  alu_req_t stage_req,
    input  alu_ctl_t stage_ctl,
    input  cc_t      cc_in,
    output alu_out_t out
);

    word_t                       a;
    word_t                       b;
    byte_t                       a_lo;
    byte_t                       b_lo;
    logic [3:0]                  msb;
    logic                        cy;
    word_t                       r;
    word_t                       r_hi;
    cc_t                         f;
    logic [`ALU_BYTE_W:0]        sum8;
    logic [`ALU_WORD_W:0]        sum16;
    logic [2*`ALU_WORD_W-1:0]    prod;
    logic [3:0]                  adj_hi;
    logic [3:0]                  adj_lo;

    assign a    = stage_req.opnd0;
    assign b    = stage_req.opnd1;
    assign a_lo = a[`ALU_BYTE_W-1:0];
    assign b_lo = b[`ALU_BYTE_W-1:0];
    assign cy   = cc_in[`CC_C];
    assign msb  = stage_ctl.wide ? 4'(`ALU_WORD_W-1) : 4'(`ALU_BYTE_W-1);

    always_comb begin
        f      = cc_in;               // Untouched flags pass through
        r      = a;                   // 8-bit ops keep the upper byte
        r_hi   = '0;
        sum8   = '0;
        sum16  = '0;
        prod   = '0;
        adj_hi = 4'h0;
        adj_lo = 4'h0;
        case (stage_req.op)
            op_ld: begin
                r         = b;
                f[`CC_V]  = 1'b0;
            end
            op_lea: r = a;
            op_add8, op_adc8: begin
                sum8 = {1'b0, a_lo} + {1'b0, b_lo};
                if (stage_req.op == op_adc8) begin
                    sum8 = sum8 + {8'd0, cy};
                end
                r[7:0]   = sum8[7:0];
                f[`CC_C] = sum8[8];
                f[`CC_V] = ~(a_lo[7] ^ b_lo[7]) & (a_lo[7] ^ sum8[7]);
                f[`CC_H] = a_lo[4] ^ b_lo[4] ^ sum8[4];
            end
            op_add16: begin
                sum16    = {1'b0, a} + {1'b0, b};
                r        = sum16[15:0];
                f[`CC_C] = sum16[16];
                f[`CC_V] = ~(a[15] ^ b[15]) & (a[15] ^ sum16[15]);
            end
            op_sub8, op_sbc8: begin
                sum8 = {1'b0, a_lo} - {1'b0, b_lo};
                if (stage_req.op == op_sbc8) begin
                    sum8 = sum8 - {8'd0, cy};
                end
                r[7:0]   = sum8[7:0];
                f[`CC_C] = sum8[8];   // Borrow
                f[`CC_V] = (a_lo[7] ^ b_lo[7]) & (a_lo[7] ^ sum8[7]);
            end
            op_sub16: begin
                sum16    = {1'b0, a} - {1'b0, b};
                r        = sum16[15:0];
                f[`CC_C] = sum16[16];
                f[`CC_V] = (a[15] ^ b[15]) & (a[15] ^ sum16[15]);
            end
            op_and: begin
                r        = a & b;
                f[`CC_V] = 1'b0;
            end
            op_eor: begin
                r        = a ^ b;
                f[`CC_V] = 1'b0;
            end
            op_or: begin
                r        = a | b;
                f[`CC_V] = 1'b0;
            end
            op_andcc: f = cc_in & b_lo;   // Clears mask or flag bits
            op_orcc:  f = cc_in | b_lo;
            op_clr: begin
                r        = '0;
                f[`CC_C] = 1'b0;
                f[`CC_V] = 1'b0;
            end
            op_com: begin
                r        = ~a;
                f[`CC_C] = 1'b1;
                f[`CC_V] = 1'b0;
            end
            op_neg8: begin
                sum8     = {1'b0, ~a_lo} + 9'd1;
                r[7:0]   = sum8[7:0];
                f[`CC_C] = ~sum8[8];
                f[`CC_V] = a_lo[7] == sum8[7];
            end
            op_neg16: begin
                sum16    = {1'b0, ~a} + 17'd1;
                r        = sum16[15:0];
                f[`CC_C] = ~sum16[16];
                f[`CC_V] = a[15] == sum16[15];
            end
            op_inc8, op_dec8: begin
                r[7:0]   = (stage_req.op == op_inc8) ? a_lo + 8'd1 : a_lo - 8'd1;
                f[`CC_V] = a_lo[7] ^ r[7];
            end
            op_inc16, op_dec16: begin
                r        = (stage_req.op == op_inc16) ? a + 16'd1 : a - 16'd1;
                f[`CC_V] = a[15] ^ r[15];
            end
            op_lsr8:  {r[7:0], f[`CC_C]} = {1'b0, a_lo};
            op_lsr16: {r, f[`CC_C]}      = {1'b0, a};
            op_asr8:  {r[7:0], f[`CC_C]} = {a_lo[7], a_lo};   // Sign bit stays
            op_ror8:  {r[7:0], f[`CC_C]} = {cy, a_lo};
            op_asl8: begin
                {f[`CC_C], r[7:0]} = {a_lo, 1'b0};
                f[`CC_V]           = a_lo[7] ^ r[7];
            end
            op_rol8: begin
                {f[`CC_C], r[7:0]} = {a_lo, cy};
                f[`CC_V]           = a_lo[7] ^ r[7];
            end
            op_daa: begin
                if (cy || a_lo[7:4] > 4'h9 || (a_lo[7:4] > 4'h8 && a_lo[3:0] > 4'h9)) begin
                    adj_hi = 4'h6;
                end
                if (cc_in[`CC_H] || a_lo[3:0] > 4'h9) begin
                    adj_lo = 4'h6;
                end
                sum8     = {1'b0, a_lo} + {1'b0, adj_hi, adj_lo};
                r[7:0]   = sum8[7:0];
                f[`CC_C] = cy | sum8[8];  // Decimal carry is sticky
            end
            op_sex: begin
                r        = {{8{a_lo[7]}}, a_lo};
                f[`CC_V] = 1'b0;
            end
            op_mul: begin
                r        = a[15:8] * a[7:0];
                f[`CC_C] = r[7];          // Rounding hint
            end
            op_lmul: begin
                prod        = a * b;
                {r_hi, r}   = prod;
                f[`CC_C]    = prod[31];
            end
            op_abs8: begin
                if (a_lo[7]) begin
                    r[7:0] = -a_lo;
                end
                f[`CC_C] = 1'b0;
                f[`CC_V] = 1'b0;
            end
            op_abs16: begin
                if (a[15]) begin
                    r = -a;
                end
                f[`CC_C] = 1'b0;
                f[`CC_V] = 1'b0;
            end
            default: r = a;
        endcase

        // Common Z and N rules
        if (stage_ctl.up_z) begin
            f[`CC_Z] = stage_ctl.wide ? (r == '0) : (r[7:0] == 8'd0);
        end
        if (stage_ctl.up_n) begin
            f[`CC_N] = r[msb];
        end

        out.rslt    = r;
        out.rslt_hi = r_hi;
        out.cc      = f;
    end

endmodule

/* src/div_unit.sv */
`timescale 1ns/1ps

`include "alu_cfg.svh"

module div_unit import alu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t dividend,
    input  byte_t divisor,
    output word_t quot,
    output byte_t rem,
    output logic  v,
    output logic  done_div,
    output logic  running
);

    localparam int CNT_W = $clog2(`ALU_DIV_STEPS) + 1;

    logic [CNT_W-1:0]   cnt;
    word_t              quot_q;
    byte_t              rem_q;
    byte_t              dvsr;
    word_t              q_src;
    byte_t              r_src;
    byte_t              d_src;
    logic [`ALU_BYTE_W:0] trial;
    logic [`ALU_BYTE_W:0] diff;
    logic               take;
    word_t              q_next;
    byte_t              r_next;

    // One restoring step; the first step runs on the start edge
    always_comb begin
        q_src  = start ? dividend : quot_q;
        r_src  = start ? '0 : rem_q;
        d_src  = start ? divisor : dvsr;
        trial  = {r_src, q_src[`ALU_WORD_W-1]};
        diff   = trial - {1'b0, d_src};
        take   = trial >= {1'b0, d_src};
        r_next = take ? diff[7:0] : trial[7:0];
        q_next = {q_src[`ALU_WORD_W-2:0], take};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            running  <= 1'b0;
            done_div <= 1'b0;
            v        <= 1'b0;
        end else begin
            done_div <= 1'b0;
            if (start) begin
                cnt     <= CNT_W'(`ALU_DIV_STEPS - 1);
                running <= 1'b1;
                v       <= divisor == '0;     // Quotient saturates to all ones
            end else if (running) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    running  <= 1'b0;
                    done_div <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            quot_q <= q_next;
            rem_q  <= r_next;
        end
        if (start) begin
            dvsr <= divisor;
        end
    end

    assign quot = quot_q;
    assign rem  = rem_q;

endmodule

/* src/alu_exec.sv */
`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_exec import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  alu_req_t req,
    output word_t    rslt,
    output word_t    rslt_hi,
    output cc_t      cc,
    output logic     done,
    output logic     busy
);

    logic     stage_valid;
    alu_req_t stage_req;
    alu_ctl_t stage_ctl;
    alu_out_t core_out;
    logic     div_start;
    logic     div_done;
    logic     div_running;
    logic     div_v;
    word_t    div_quot;
    byte_t    div_rem;
    logic     div_pending;

    // Division waiting in the stage, not yet finished
    assign div_pending = stage_valid & stage_ctl.is_div & ~div_done;
    assign div_start   = div_pending & ~div_running;
    assign busy        = div_pending | div_running;

    op_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .hold        (busy),          // Stage keeps the division
        .req         (req),
        .stage_valid (stage_valid),
        .stage_req   (stage_req),
        .stage_ctl   (stage_ctl)
    );

    alu_core u_core (
        .stage_req (stage_req),
        .stage_ctl (stage_ctl),
        .cc_in     (cc),
        .out       (core_out)
    );

    div_unit u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (stage_req.opnd0),
        .divisor  (stage_req.opnd1[`ALU_BYTE_W-1:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .v        (div_v),
        .done_div (div_done),
        .running  (div_running)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rslt    <= '0;
            rslt_hi <= '0;
            cc      <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (div_done) begin
                rslt        <= div_quot;
                rslt_hi     <= {{(`ALU_WORD_W-`ALU_BYTE_W){1'b0}}, div_rem};
                cc[`CC_V]   <= div_v;
                cc[`CC_Z]   <= div_quot == '0;
                done        <= 1'b1;
            end else if (stage_valid && !stage_ctl.is_div) begin
                rslt    <= core_out.rslt;
                rslt_hi <= core_out.rslt_hi;
                cc      <= core_out.cc;   // Next op sees these flags
                done    <= 1'b1;
            end
        end
    end

endmodule

/* tb/alu_tb.sv */
`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_tb import alu_pkg::*; ();

    typedef struct packed {
        word_t       rslt;
        word_t       hi;
        cc_t         cc;
        logic [31:0] due;             // Cycle count when done is due
    } exp_t;

    localparam int N_ARITH = 15;
    localparam int N_LOGIC = 13;
    localparam int N_SPEC  = 12;
    localparam int TBL_N   = N_ARITH + N_LOGIC + N_SPEC;

    logic        clk;
    logic        rst;
    logic        issue;
    alu_req_t    req;
    word_t       rslt;
    word_t       rslt_hi;
    cc_t         cc;
    logic        done;
    logic        busy;

    cc_t         mcc;                 // Model flags
    exp_t        exp_q[$];
    exp_t        head;
    int          cyc;
    int          errors;
    int          checks;
    int          tests;
    int          mark;
    bit          aborted;
    logic [15:0] lfsr;
    word_t       ra;
    word_t       rb;

    // op, opnd0, opnd1
    alu_req_t tbl [TBL_N] = '{
        {op_add8,  16'h127f, 16'h0001},   // Signed overflow
        {op_add8,  16'h00ff, 16'h0001},   // Carry, zero, half carry
        {op_adc8,  16'h0010, 16'h0020},
        {op_add16, 16'h7fff, 16'h0001},
        {op_add16, 16'hffff, 16'h0001},
        {op_sub8,  16'h0000, 16'h0001},   // Borrow
        {op_sbc8,  16'h0050, 16'h0010},
        {op_sub8,  16'h0080, 16'h0001},
        {op_sub16, 16'h8000, 16'h0001},
        {op_neg8,  16'h0080, 16'h0000},
        {op_neg16, 16'h0001, 16'h0000},
        {op_inc8,  16'h007f, 16'h0000},
        {op_inc16, 16'hffff, 16'h0000},
        {op_dec8,  16'h0080, 16'h0000},
        {op_dec16, 16'h0000, 16'h0000},
        {op_and,   16'hf0f0, 16'h0ff0},   // Back to back from here
        {op_eor,   16'hffff, 16'h8001},
        {op_or,    16'h8f00, 16'h00f0},
        {op_com,   16'h00ff, 16'h0000},
        {op_ror8,  16'h0002, 16'h0000},
        {op_rol8,  16'h0081, 16'h0000},
        {op_rol8,  16'h0040, 16'h0000},
        {op_lsr8,  16'h0001, 16'h0000},
        {op_asr8,  16'h0081, 16'h0000},
        {op_asl8,  16'h00c0, 16'h0000},
        {op_lsr16, 16'h8001, 16'h0000},
        {op_clr,   16'h1234, 16'h0000},
        {op_ror8,  16'h0001, 16'h0000},
        {op_mul,   16'hff80, 16'h0000},
        {op_lmul,  16'h1234, 16'h5678},
        {op_add8,  16'h0099, 16'h0099},   // Sets C and H for DAA
        {op_daa,   16'h0032, 16'h0000},
        {op_sex,   16'h0080, 16'h0000},
        {op_abs8,  16'h12f0, 16'h0000},
        {op_abs16, 16'h8000, 16'h0000},
        {op_abs16, 16'h0000, 16'h0000},
        {op_ld,    16'h1234, 16'h8000},
        {op_lea,   16'h0000, 16'h1111},
        {op_orcc,  16'h4321, 16'h0050},
        {op_andcc, 16'h4321, 16'h00af}
    };

    alu_exec dut_i (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .req     (req),
        .rslt    (rslt),
        .rslt_hi (rslt_hi),
        .cc      (cc),
        .done    (done),
        .busy    (busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Each done retires the oldest expected result
    always @(negedge clk) begin
        if (!rst && done) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("CHECK FAILED at %0t: done with no request in flight", $time);
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                assert (rslt == head.rslt && rslt_hi == head.hi && cc == head.cc) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: got %h:%h cc %h, expected %h:%h cc %h",
                             $time, rslt_hi, rslt, cc, head.hi, head.rslt, head.cc);
                end
                assert (cyc == int'(head.due)) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: done on cycle %0d, expected cycle %0d",
                             $time, cyc, head.due);
                end
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic rand_word(input int nbits, output word_t v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    // Reference model, advances mcc in issue order
    task automatic model_op(input alu_req_t q, output word_t r, output word_t hi);
        byte_t       a8;
        byte_t       b8;
        byte_t       r8;
        byte_t       fix;
        logic        cin;
        logic        w;
        logic        nz_n;
        logic        nz_z;
        int          d;
        logic [31:0] p;
        a8   = q.opnd0[7:0];
        b8   = q.opnd1[7:0];
        r8   = a8;
        cin  = mcc[`CC_C];
        r    = q.opnd0;
        hi   = '0;
        w    = 1'b1;
        nz_n = 1'b1;
        nz_z = 1'b1;
        case (q.op)
            op_ld: begin
                r          = q.opnd1;
                mcc[`CC_V] = 1'b0;
            end
            op_lea: nz_n = 1'b0;
            op_add8, op_adc8: begin
                d          = int'(a8) + int'(b8) + ((q.op == op_adc8) ? int'(cin) : 0);
                r8         = d[7:0];
                w          = 1'b0;
                mcc[`CC_C] = d > 255;
                mcc[`CC_V] = a8[7] == b8[7] && r8[7] != a8[7];
                mcc[`CC_H] = a8[4] ^ b8[4] ^ r8[4];
            end
            op_add16: begin
                d          = int'(q.opnd0) + int'(q.opnd1);
                r          = d[15:0];
                mcc[`CC_C] = d > 65535;
                mcc[`CC_V] = q.opnd0[15] == q.opnd1[15] && r[15] != q.opnd0[15];
            end
            op_sub8, op_sbc8: begin
                d          = int'(a8) - int'(b8) - ((q.op == op_sbc8) ? int'(cin) : 0);
                r8         = d[7:0];
                w          = 1'b0;
                mcc[`CC_C] = d < 0;
                mcc[`CC_V] = a8[7] != b8[7] && r8[7] != a8[7];
            end
            op_sub16: begin
                d          = int'(q.opnd0) - int'(q.opnd1);
                r          = d[15:0];
                mcc[`CC_C] = d < 0;
                mcc[`CC_V] = q.opnd0[15] != q.opnd1[15] && r[15] != q.opnd0[15];
            end
            op_and, op_eor, op_or: begin
                if (q.op == op_and) r = q.opnd0 & q.opnd1;
                if (q.op == op_eor) r = q.opnd0 ^ q.opnd1;
                if (q.op == op_or) r = q.opnd0 | q.opnd1;
                mcc[`CC_V] = 1'b0;
            end
            op_andcc, op_orcc: begin
                mcc  = (q.op == op_andcc) ? (mcc & b8) : (mcc | b8);
                nz_n = 1'b0;
                nz_z = 1'b0;
            end
            op_clr, op_com: begin
                r          = (q.op == op_clr) ? 16'h0000 : ~q.opnd0;
                mcc[`CC_C] = q.op == op_com;
                mcc[`CC_V] = 1'b0;
            end
            op_neg8: begin
                r8         = 8'd0 - a8;
                w          = 1'b0;
                mcc[`CC_C] = a8 != 8'd0;
                mcc[`CC_V] = r8[7] == a8[7];
            end
            op_neg16: begin
                r          = 16'd0 - q.opnd0;
                mcc[`CC_C] = q.opnd0 != 16'd0;
                mcc[`CC_V] = r[15] == q.opnd0[15];
            end
            op_inc8, op_dec8: begin
                r8         = (q.op == op_inc8) ? a8 + 8'd1 : a8 - 8'd1;
                w          = 1'b0;
                mcc[`CC_V] = r8[7] != a8[7];
            end
            op_inc16, op_dec16: begin
                r          = (q.op == op_inc16) ? q.opnd0 + 16'd1 : q.opnd0 - 16'd1;
                mcc[`CC_V] = r[15] != q.opnd0[15];
            end
            op_lsr8, op_asr8, op_ror8: begin
                if (q.op == op_lsr8) r8 = {1'b0, a8[7:1]};
                if (q.op == op_asr8) r8 = {a8[7], a8[7:1]};
                if (q.op == op_ror8) r8 = {cin, a8[7:1]};
                w          = 1'b0;
                mcc[`CC_C] = a8[0];
            end
            op_lsr16: begin
                r          = q.opnd0 >> 1;
                mcc[`CC_C] = q.opnd0[0];
            end
            op_asl8, op_rol8: begin
                r8         = {a8[6:0], (q.op == op_rol8) ? cin : 1'b0};
                w          = 1'b0;
                mcc[`CC_C] = a8[7];
                mcc[`CC_V] = r8[7] != a8[7];
            end
            op_daa: begin
                fix = 8'h00;
                if (mcc[`CC_H] || a8[3:0] > 4'd9) fix[3:0] = 4'h6;
                if (cin || a8[7:4] > 4'd9 || (a8[7:4] > 4'd8 && a8[3:0] > 4'd9)) fix[7:4] = 4'h6;
                d          = int'(a8) + int'(fix);
                r8         = d[7:0];
                w          = 1'b0;
                mcc[`CC_C] = cin || d > 255;
            end
            op_sex: begin
                r          = {{8{a8[7]}}, a8};
                mcc[`CC_V] = 1'b0;
            end
            op_mul: begin
                r          = 16'(q.opnd0[15:8]) * 16'(q.opnd0[7:0]);
                mcc[`CC_C] = r[7];
                nz_n       = 1'b0;
            end
            op_lmul: begin
                p          = 32'(q.opnd0) * 32'(q.opnd1);
                {hi, r}    = p;
                mcc[`CC_C] = p[31];
                nz_n       = 1'b0;
            end
            op_abs8, op_abs16: begin
                if (q.op == op_abs8 && a8[7]) r8 = 8'd0 - a8;
                if (q.op == op_abs16 && q.opnd0[15]) r = 16'd0 - q.opnd0;
                w          = q.op == op_abs16;
                nz_z       = 1'b0;
                mcc[`CC_C] = 1'b0;
                mcc[`CC_V] = 1'b0;
            end
            op_div: begin
                r          = (b8 == 8'd0) ? 16'hffff : q.opnd0 / 16'(b8);
                hi         = (b8 == 8'd0) ? 16'(a8) : q.opnd0 % 16'(b8);
                mcc[`CC_V] = b8 == 8'd0;
                nz_n       = 1'b0;
            end
            default: ;
        endcase
        if (!w) r[7:0] = r8;          // Upper byte kept from opnd0
        if (nz_z) mcc[`CC_Z] = w ? (r == 16'd0) : (r[7:0] == 8'd0);
        if (nz_n) mcc[`CC_N] = w ? r[15] : r[7];
    endtask

    task automatic issue_req(input alu_req_t q);
        exp_t  e;
        word_t r;
        word_t hi;
        model_op(q, r, hi);
        @(posedge clk);
        #2;
        e.rslt = r;
        e.hi   = hi;
        e.cc   = mcc;
        e.due  = 32'(cyc + 2 + ((q.op == op_div) ? `ALU_DIV_STEPS : 0));
        exp_q.push_back(e);
        issue  = 1'b1;
        req    = q;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        issue = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t: %0d results missing after %0d cycles",
                     $time, exp_q.size(), limit);
            errors++;
            aborted = 1'b1;
            exp_q.delete();
        end
    endtask

    task automatic run_table(input int lo, input int hi, input bit back_to_back);
        for (int i = lo; i <= hi && !aborted; i++) begin
            issue_req(tbl[i]);
            if (!back_to_back) begin
                drive_idle();
                wait_idle(8);
            end
        end
        drive_idle();
        wait_idle(8);
    endtask

    // poke issues one extra request while the divider is busy
    task automatic run_div(input word_t dvd, input byte_t dvs, input bit poke);
        int n;
        issue_req({op_div, dvd, {8'h00, dvs}});
        drive_idle();
        n = 0;
        while (!done && n < 4 * `ALU_DIV_STEPS) begin
            if (n < `ALU_DIV_STEPS) begin
                checks++;
                assert (busy) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: busy low %0d cycles into a division",
                             $time, n);
                end
            end
            issue = poke && n == 3;
            if (poke && n == 3) req = {op_add8, 16'h0001, 16'h0001};
            @(posedge clk);
            #2;
            n++;
        end
        issue = 1'b0;
        if (!done) begin
            $display("Timeout at %0t: division gave no done in %0d cycles", $time, n);
            errors++;
            aborted = 1'b1;
        end
        repeat (3) @(posedge clk);    // Room for a stray done
        wait_idle(4);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-8s %s", name, (errors == mark) ? "pass" : "fail");
        mark = errors;
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        issue   = 1'b0;
        req     = '0;
        mcc     = '0;
        cyc     = 0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        mark    = 0;
        aborted = 1'b0;
        lfsr    = 16'd79;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checks++;
        assert (cc == '0 && rslt == '0 && rslt_hi == '0 && !done && !busy) else begin
            errors++;
            $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
        end
        end_test("reset");
        if (!aborted) begin
            run_table(0, N_ARITH - 1, 1'b0);
            end_test("arith");
        end
        if (!aborted) begin
            run_table(N_ARITH, N_ARITH + N_LOGIC - 1, 1'b1);
            end_test("logic");
        end
        if (!aborted) begin
            run_table(N_ARITH + N_LOGIC, TBL_N - 1, 1'b0);
            end_test("special");
        end
        for (int i = 0; i < 4 && !aborted; i++) begin
            rand_word(16, ra);
            rand_word(8, rb);
            run_div(ra, rb[7:0], 1'b0);
        end
        if (!aborted) run_div(16'h1234, 8'h00, 1'b0);
        if (!aborted) run_div(16'hbeef, 8'h07, 1'b1);
        end_test("divide");
        for (int i = 0; i < 10 && !aborted; i++) begin
            rand_word(16, ra);
            rand_word(16, rb);
            issue_req({(i % 2 == 0) ? op_add16 : op_sub16, ra, rb});
        end
        drive_idle();
        wait_idle(8);
        end_test("random");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/alu_pkg.sv
src/op_decode.sv
src/alu_core.sv
src/div_unit.sv
src/alu_exec.sv
tb/alu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module alu_tb
out=$(./obj_dir/Valu_tb)
echo "$out"
if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
